/* common/ctl_pkg.sv */
package ctl_pkg;

    // ##########################################################
    // widths and memory
    // ##########################################################

    localparam int ADDR_WIDTH       = 8;
    localparam int WORD_WIDTH       = 16;
    localparam int RAM_DEPTH        = 1 << ADDR_WIDTH;
    localparam int RAM_READ_LATENCY = 2;   // address register plus output register

    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [15:0]           ctl_flags_t;
    typedef logic [63:0]           sync_time_t;
    typedef logic [15:0]           rate_t;
    typedef logic [7:0]            silencer_flag_t;

    // ##########################################################
    // register map
    // ##########################################################

    localparam reg_addr_t ADDR_CTL_FLAG          = 8'h00;
    localparam reg_addr_t ADDR_FPGA_STATE        = 8'h01;
    localparam reg_addr_t ADDR_VERSION_NUM_MAJOR = 8'h02;
    localparam reg_addr_t ADDR_VERSION_NUM_MINOR = 8'h03;

    localparam reg_addr_t ADDR_SILENCER_FLAG                       = 8'h40;
    localparam reg_addr_t ADDR_SILENCER_UPDATE_RATE_INTENSITY      = 8'h41;
    localparam reg_addr_t ADDR_SILENCER_UPDATE_RATE_PHASE          = 8'h42;
    localparam reg_addr_t ADDR_SILENCER_COMPLETION_STEPS_INTENSITY = 8'h43;
    localparam reg_addr_t ADDR_SILENCER_COMPLETION_STEPS_PHASE     = 8'h44;

    localparam reg_addr_t ADDR_SYNC_TIME_0 = 8'h50;   // lowest word of the 64-bit time
    localparam reg_addr_t ADDR_SYNC_TIME_1 = 8'h51;
    localparam reg_addr_t ADDR_SYNC_TIME_2 = 8'h52;
    localparam reg_addr_t ADDR_SYNC_TIME_3 = 8'h53;

    localparam int CTL_FLAG_BIT_SILENCER_SET = 2;
    localparam int CTL_FLAG_BIT_SYNC_SET     = 3;
    localparam int CTL_FLAG_BIT_FORCE_FAN    = 4;
    localparam int CTL_FLAG_BIT_GPIO_IN_0    = 8;
    localparam int CTL_FLAG_BIT_GPIO_IN_1    = 9;
    localparam int CTL_FLAG_BIT_GPIO_IN_2    = 10;
    localparam int CTL_FLAG_BIT_GPIO_IN_3    = 11;

    localparam int FPGA_STATE_BIT_THERMO = 0;

    localparam logic [7:0] VERSION_NUM_MAJOR = 8'h0A;
    localparam logic [7:0] VERSION_NUM_MINOR = 8'h01;

    // ##########################################################
    // settings reset values
    // ##########################################################

    localparam silencer_flag_t SILENCER_FLAG_RST        = 8'd0;
    localparam rate_t          SILENCER_RATE_INT_RST    = 16'd256;
    localparam rate_t          SILENCER_RATE_PHASE_RST  = 16'd256;
    localparam rate_t          SILENCER_STEPS_INT_RST   = 16'd10;
    localparam rate_t          SILENCER_STEPS_PHASE_RST = 16'd40;
    localparam sync_time_t     SYNC_TIME_RST            = 64'd0;

    // order matters, a group burst steps through consecutive values
    typedef enum logic [3:0] {
        SIL_FLAG,
        SIL_RATE_INT,
        SIL_RATE_PHASE,
        SIL_STEPS_INT,
        SIL_STEPS_PHASE,
        SYNC_T0,
        SYNC_T1,
        SYNC_T2,
        SYNC_T3,
        CTL_FLAGS,
        NONE
    } cap_field_t;

    typedef enum logic [2:0] {
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_POLL_RD,
        ST_POLL_WR,
        ST_BURST,
        ST_WB_FLAGS,
        ST_WB_STATE
    } seq_state_t;

endpackage

/* hw/cnt_ram.sv */
`timescale 1ns/1ps

module cnt_ram import ctl_pkg::*; (
    input  logic      CLK,
    input  logic      host_we,
    input  reg_addr_t host_addr,
    input  word_t     host_din,
    input  logic      bus_we,
    input  reg_addr_t bus_addr,
    input  word_t     bus_din,
    output word_t     host_dout,
    output word_t     bus_dout
);

    word_t     mem [RAM_DEPTH];
    reg_addr_t host_addr_q;
    reg_addr_t bus_addr_q;

    // block RAM comes up cleared after configuration
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (host_we) begin
            mem[host_addr] <= host_din;
        end
        if (bus_we) begin
            mem[bus_addr] <= bus_din;   // last assignment wins, so the controller port has priority
        end
    end

    // ##########################################################
    // read path, two register stages per port
    // ##########################################################

    always_ff @(posedge CLK) begin
        host_addr_q <= host_addr;
        bus_addr_q  <= bus_addr;
        host_dout   <= mem[host_addr_q];
        bus_dout    <= mem[bus_addr_q];
    end

endmodule

/* ctl_sequencer/ctl_sequencer.sv */
`timescale 1ns/1ps

module ctl_sequencer import ctl_pkg::*; (
    input  logic       CLK,
    input  logic       rst_n,
    input  logic       thermo,
    input  word_t      bus_dout,
    output logic       bus_we,
    output reg_addr_t  bus_addr,
    output word_t      bus_din,
    output cap_field_t cap_field,
    output logic       force_fan,
    output logic [3:0] gpio_in
);

    seq_state_t state;
    ctl_flags_t ctl_flags;                  // local copy, written back after a group
    cap_field_t burst_tag;                  // next group word to request
    cap_field_t req_tag;                    // names the read currently on bus_addr
    cap_field_t tag_pipe [RAM_READ_LATENCY];
    word_t      state_word;

    function automatic reg_addr_t tag_addr(cap_field_t field);
        case (field)
            SIL_FLAG:        return ADDR_SILENCER_FLAG;
            SIL_RATE_INT:    return ADDR_SILENCER_UPDATE_RATE_INTENSITY;
            SIL_RATE_PHASE:  return ADDR_SILENCER_UPDATE_RATE_PHASE;
            SIL_STEPS_INT:   return ADDR_SILENCER_COMPLETION_STEPS_INTENSITY;
            SIL_STEPS_PHASE: return ADDR_SILENCER_COMPLETION_STEPS_PHASE;
            SYNC_T0:         return ADDR_SYNC_TIME_0;
            SYNC_T1:         return ADDR_SYNC_TIME_1;
            SYNC_T2:         return ADDR_SYNC_TIME_2;
            SYNC_T3:         return ADDR_SYNC_TIME_3;
            default:         return ADDR_CTL_FLAG;
        endcase
    endfunction

    always_comb begin
        state_word = '0;
        state_word[FPGA_STATE_BIT_THERMO] = thermo;
    end

    assign force_fan = ctl_flags[CTL_FLAG_BIT_FORCE_FAN];
    assign gpio_in   = {ctl_flags[CTL_FLAG_BIT_GPIO_IN_3], ctl_flags[CTL_FLAG_BIT_GPIO_IN_2],
                        ctl_flags[CTL_FLAG_BIT_GPIO_IN_1], ctl_flags[CTL_FLAG_BIT_GPIO_IN_0]};

    // ##########################################################
    // access sequencer
    // ##########################################################

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state     <= ST_VER_MINOR;
            bus_we    <= 1'b0;
            bus_addr  <= ADDR_CTL_FLAG;
            req_tag   <= NONE;
            burst_tag <= NONE;
            ctl_flags <= '0;
        end else begin
            req_tag <= NONE;
            case (state)
                ST_VER_MINOR: begin
                    bus_we   <= 1'b1;
                    bus_addr <= ADDR_VERSION_NUM_MINOR;
                    bus_din  <= {8'h00, VERSION_NUM_MINOR};
                    state    <= ST_VER_MAJOR;
                end
                ST_VER_MAJOR: begin
                    bus_we   <= 1'b1;
                    bus_addr <= ADDR_VERSION_NUM_MAJOR;
                    bus_din  <= {8'h00, VERSION_NUM_MAJOR};
                    state    <= ST_POLL_RD;
                end
                ST_POLL_RD: begin
                    bus_we   <= 1'b0;
                    bus_addr <= ADDR_CTL_FLAG;
                    req_tag  <= CTL_FLAGS;
                    state    <= ST_POLL_WR;
                end
                ST_POLL_WR: begin
                    bus_we   <= 1'b1;
                    bus_addr <= ADDR_FPGA_STATE;
                    bus_din  <= state_word;
                    state    <= ST_POLL_RD;
                    // the flag read issued two states ago lands here
                    if (cap_field == CTL_FLAGS) begin
                        ctl_flags <= bus_dout;
                        if (bus_dout[CTL_FLAG_BIT_SILENCER_SET]) begin
                            ctl_flags[CTL_FLAG_BIT_SILENCER_SET] <= 1'b0;
                            burst_tag <= SIL_FLAG;
                            state     <= ST_BURST;
                        end else if (bus_dout[CTL_FLAG_BIT_SYNC_SET]) begin
                            ctl_flags[CTL_FLAG_BIT_SYNC_SET] <= 1'b0;
                            burst_tag <= SYNC_T0;
                            state     <= ST_BURST;
                        end
                    end
                end
                ST_BURST: begin
                    bus_we   <= 1'b0;
                    bus_addr <= tag_addr(burst_tag);
                    req_tag  <= burst_tag;
                    if (burst_tag == SIL_STEPS_PHASE || burst_tag == SYNC_T3) begin
                        state <= ST_WB_FLAGS;
                    end else begin
                        burst_tag <= cap_field_t'(burst_tag + 4'd1);
                    end
                end
                ST_WB_FLAGS: begin
                    bus_we   <= 1'b1;
                    bus_addr <= ADDR_CTL_FLAG;
                    bus_din  <= ctl_flags;
                    state    <= ST_WB_STATE;
                end
                ST_WB_STATE: begin
                    bus_we   <= 1'b1;
                    bus_addr <= ADDR_FPGA_STATE;
                    bus_din  <= state_word;
                    state    <= ST_POLL_RD;
                end
                default: begin
                    bus_we <= 1'b0;
                    state  <= ST_POLL_RD;
                end
            endcase
        end
    end

    // tag delay line matching the memory read latency
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < RAM_READ_LATENCY; i++) begin
                tag_pipe[i] <= NONE;
            end
        end else begin
            tag_pipe[0] <= req_tag;
            for (int i = 1; i < RAM_READ_LATENCY; i++) begin
                tag_pipe[i] <= tag_pipe[i-1];
            end
        end
    end

    assign cap_field = tag_pipe[RAM_READ_LATENCY-1];

endmodule

/* hw/settings_capture.sv */
`timescale 1ns/1ps

module settings_capture import ctl_pkg::*; (
    input  logic           CLK,
    input  logic           rst_n,
    input  cap_field_t     cap_field,
    input  word_t          bus_dout,
    output silencer_flag_t silencer_flag,
    output rate_t          silencer_rate_intensity,
    output rate_t          silencer_rate_phase,
    output rate_t          silencer_steps_intensity,
    output rate_t          silencer_steps_phase,
    output sync_time_t     sync_time,
    output logic           silencer_update,
    output logic           sync_update
);

    // ##########################################################
    // field capture
    // ##########################################################

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            silencer_flag            <= SILENCER_FLAG_RST;
            silencer_rate_intensity  <= SILENCER_RATE_INT_RST;
            silencer_rate_phase      <= SILENCER_RATE_PHASE_RST;
            silencer_steps_intensity <= SILENCER_STEPS_INT_RST;
            silencer_steps_phase     <= SILENCER_STEPS_PHASE_RST;
            sync_time                <= SYNC_TIME_RST;
            silencer_update          <= 1'b0;
            sync_update              <= 1'b0;
        end else begin
            silencer_update <= 1'b0;
            sync_update     <= 1'b0;
            case (cap_field)
                SIL_FLAG: begin
                    silencer_flag <= bus_dout[7:0];   // upper byte is reserved
                end
                SIL_RATE_INT: begin
                    silencer_rate_intensity <= bus_dout;
                end
                SIL_RATE_PHASE: begin
                    silencer_rate_phase <= bus_dout;
                end
                SIL_STEPS_INT: begin
                    silencer_steps_intensity <= bus_dout;
                end
                SIL_STEPS_PHASE: begin
                    silencer_steps_phase <= bus_dout;
                    silencer_update      <= 1'b1;   // last word of the silencer group
                end
                SYNC_T0: begin
                    sync_time[15:0] <= bus_dout;
                end
                SYNC_T1: begin
                    sync_time[31:16] <= bus_dout;
                end
                SYNC_T2: begin
                    sync_time[47:32] <= bus_dout;
                end
                SYNC_T3: begin
                    sync_time[63:48] <= bus_dout;
                    sync_update      <= 1'b1;
                end
                default: begin
                    // flag reads and idle cycles carry nothing for the settings
                end
            endcase
        end
    end

endmodule

/* hw/fpga_controller.sv */
`timescale 1ns/1ps

module fpga_controller import ctl_pkg::*; (
    input  logic           CLK,
    input  logic           rst_n,
    input  logic           thermo,
    input  logic           host_we,
    input  reg_addr_t      host_addr,
    input  word_t          host_din,
    output word_t          host_dout,
    output logic           force_fan,
    output logic [3:0]     gpio_in,
    output silencer_flag_t silencer_flag,
    output rate_t          silencer_rate_intensity,
    output rate_t          silencer_rate_phase,
    output rate_t          silencer_steps_intensity,
    output rate_t          silencer_steps_phase,
    output sync_time_t     sync_time,
    output logic           silencer_update,
    output logic           sync_update
);

    logic       bus_we;
    reg_addr_t  bus_addr;
    word_t      bus_din;
    word_t      bus_dout;
    cap_field_t cap_field;   // tag aligned with bus_dout

    cnt_ram cnt_ram_i (
        .CLK       (CLK),
        .host_we   (host_we),
        .host_addr (host_addr),
        .host_din  (host_din),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_din   (bus_din),
        .host_dout (host_dout),
        .bus_dout  (bus_dout)
    );

    ctl_sequencer ctl_sequencer_i (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .thermo    (thermo),
        .bus_dout  (bus_dout),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_din   (bus_din),
        .cap_field (cap_field),
        .force_fan (force_fan),
        .gpio_in   (gpio_in)
    );

    settings_capture settings_capture_i (
        .CLK                      (CLK),
        .rst_n                    (rst_n),
        .cap_field                (cap_field),
        .bus_dout                 (bus_dout),
        .silencer_flag            (silencer_flag),
        .silencer_rate_intensity  (silencer_rate_intensity),
        .silencer_rate_phase      (silencer_rate_phase),
        .silencer_steps_intensity (silencer_steps_intensity),
        .silencer_steps_phase     (silencer_steps_phase),
        .sync_time                (sync_time),
        .silencer_update          (silencer_update),
        .sync_update              (sync_update)
    );

endmodule

/* sim/fpga_controller_checker.sv */
`timescale 1ns/1ps

module fpga_controller_checker (
    input logic CLK,
    input logic rst_n,
    input logic bus_we,
    input logic silencer_update,
    input logic sync_update
);

    // ##########################################################
    // update strobes
    // ##########################################################

    silencer_pulse_width: assert property (
        @(posedge CLK) disable iff (!rst_n) silencer_update |=> !silencer_update
    ) else $error("silencer_update stayed high for more than one cycle");

    sync_pulse_width: assert property (
        @(posedge CLK) disable iff (!rst_n) sync_update |=> !sync_update
    ) else $error("sync_update stayed high for more than one cycle");

    // one group is serviced at a time and the flag write-back keeps the two strobes apart
    pulses_exclusive: assert property (
        @(posedge CLK) disable iff (!rst_n)
            !((silencer_update || $past(silencer_update)) && sync_update) &&
            !($past(sync_update) && silencer_update)
    ) else $error("silencer_update and sync_update were high together or back to back");

    // bus_we is registered, it reads low from the edge after reset is sampled
    bus_idle_in_reset: assert property (
        @(posedge CLK) !rst_n |=> !bus_we
    ) else $error("bus_we was high during reset");

endmodule

/* sim/tb_fpga_controller.sv */
`timescale 1ns/1ps

module tb_fpga_controller import ctl_pkg::*; ();

    localparam int PULSE_TIMEOUT = 60;   // generous bound over an update latency of about 20 cycles
    localparam int READ_TRIES    = 12;

    logic           CLK;
    logic           rst_n;
    logic           thermo;
    logic           host_we;
    reg_addr_t      host_addr;
    word_t          host_din;
    word_t          host_dout;
    logic           force_fan;
    logic [3:0]     gpio_in;
    silencer_flag_t silencer_flag;
    rate_t          silencer_rate_intensity;
    rate_t          silencer_rate_phase;
    rate_t          silencer_steps_intensity;
    rate_t          silencer_steps_phase;
    sync_time_t     sync_time;
    logic           silencer_update;
    logic           sync_update;

    int          error_count;
    int          tests_run;
    int          tests_with_errors;
    int unsigned lcg_state;
    word_t       sil_words [5];
    word_t       sync_words [4];

    fpga_controller fpga_controller_i (.*);

    bind fpga_controller fpga_controller_checker fpga_controller_checker_i (
        .CLK             (CLK),
        .rst_n           (rst_n),
        .bus_we          (bus_we),
        .silencer_update (silencer_update),
        .sync_update     (sync_update)
    );

    always #20 CLK = ~CLK;

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return word_t'(lcg_state >> 16);   // upper half has the longer period
    endfunction

    // ##########################################################
    // host port and reporting
    // ##########################################################

    task automatic host_write(input reg_addr_t addr, input word_t data);
        @(posedge CLK);
        host_we   <= 1'b1;
        host_addr <= addr;
        host_din  <= data;
        @(posedge CLK);
        host_we   <= 1'b0;
    endtask

    task automatic host_read(input reg_addr_t addr, output word_t data);
        @(posedge CLK);
        host_addr <= addr;
        repeat (2) @(posedge CLK);   // address stage, then output stage
        @(negedge CLK);
        data = host_dout;
    endtask

    task automatic report_mismatch(input string test_name, input string what,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
        error_count++;
    endtask

    task automatic report_failure(input string test_name, input string what);
        $display("%s: %s", test_name, what);
        error_count++;
    endtask

    task automatic finish_test(input string test_name, input int errors_at_start);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s done, no errors", test_name);
        end else begin
            tests_with_errors++;
            $display("test %s done, %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic wait_pulse(input bit sync_pulse, input string test_name, output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < PULSE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            seen = sync_pulse ? sync_update : silencer_update;
        end
        if (!seen) report_failure(test_name, "the update pulse did not arrive in time");
    endtask

    task automatic load_silencer_words();
        for (int i = 0; i < 5; i++) begin
            sil_words[i] = next_random();
            host_write(ADDR_SILENCER_FLAG + reg_addr_t'(i), sil_words[i]);
        end
    endtask

    task automatic load_sync_words();
        for (int i = 0; i < 4; i++) begin
            sync_words[i] = next_random();
            host_write(ADDR_SYNC_TIME_0 + reg_addr_t'(i), sync_words[i]);
        end
    endtask

    task automatic check_silencer(input string test_name);
        if (silencer_flag !== sil_words[0][7:0])   // only the low byte is a flag
            report_mismatch(test_name, "flag", 64'(sil_words[0][7:0]), 64'(silencer_flag));
        if (silencer_rate_intensity !== sil_words[1])
            report_mismatch(test_name, "rate intensity", 64'(sil_words[1]),
                            64'(silencer_rate_intensity));
        if (silencer_rate_phase !== sil_words[2])
            report_mismatch(test_name, "rate phase", 64'(sil_words[2]), 64'(silencer_rate_phase));
        if (silencer_steps_intensity !== sil_words[3])
            report_mismatch(test_name, "steps intensity", 64'(sil_words[3]),
                            64'(silencer_steps_intensity));
        if (silencer_steps_phase !== sil_words[4])
            report_mismatch(test_name, "steps phase", 64'(sil_words[4]), 64'(silencer_steps_phase));
    endtask

    task automatic check_sync(input string test_name);
        sync_time_t expected;
        expected = {sync_words[3], sync_words[2], sync_words[1], sync_words[0]};
        if (sync_time !== expected) report_mismatch(test_name, "sync time", expected, sync_time);
    endtask

    // ##########################################################
    // directed tests
    // ##########################################################

    task automatic test_version_defaults();
        int    errors_at_start;
        word_t data;
        errors_at_start = error_count;
        repeat (4) @(posedge CLK);   // both version writes land within 4 cycles
        host_read(ADDR_VERSION_NUM_MAJOR, data);
        if (data !== 16'h000A) report_mismatch("version_defaults", "major", 64'h000A, 64'(data));
        host_read(ADDR_VERSION_NUM_MINOR, data);
        if (data !== 16'h0001) report_mismatch("version_defaults", "minor", 64'h0001, 64'(data));
        if (silencer_flag !== 8'd0)
            report_mismatch("version_defaults", "flag", 64'd0, 64'(silencer_flag));
        if (silencer_rate_intensity !== 16'd256)
            report_mismatch("version_defaults", "rate int", 64'd256, 64'(silencer_rate_intensity));
        if (silencer_rate_phase !== 16'd256)
            report_mismatch("version_defaults", "rate phase", 64'd256, 64'(silencer_rate_phase));
        if (silencer_steps_intensity !== 16'd10)
            report_mismatch("version_defaults", "steps int", 64'd10, 64'(silencer_steps_intensity));
        if (silencer_steps_phase !== 16'd40)
            report_mismatch("version_defaults", "steps phase", 64'd40, 64'(silencer_steps_phase));
        if (sync_time !== 64'd0) report_mismatch("version_defaults", "sync time", 64'd0, sync_time);
        if ({force_fan, gpio_in} !== 5'd0)
            report_mismatch("version_defaults", "fan and gpio", 64'd0, 64'({force_fan, gpio_in}));
        finish_test("version_defaults", errors_at_start);
    endtask

    task automatic test_status_word();
        int    errors_at_start;
        word_t data;
        word_t expected;
        errors_at_start = error_count;
        for (int level = 1; level >= 0; level--) begin
            @(posedge CLK);
            thermo   <= level[0];
            expected = word_t'(level);   // thermal bit is bit 0, all other bits stay zero
            for (int tries = 0; tries < READ_TRIES; tries++) begin
                host_read(ADDR_FPGA_STATE, data);
                if (data === expected) break;
            end
            if (data !== expected)
                report_mismatch("status_word", "state word", 64'(expected), 64'(data));
        end
        finish_test("status_word", errors_at_start);
    endtask

    task automatic test_silencer_update();
        int    errors_at_start;
        bit    seen;
        word_t data;
        errors_at_start = error_count;
        load_silencer_words();
        host_write(ADDR_CTL_FLAG, 16'h0004);   // silencer-set is bit 2
        wait_pulse(1'b0, "silencer_update", seen);
        if (seen) check_silencer("silencer_update");
        host_read(ADDR_CTL_FLAG, data);
        if (data[2] !== 1'b0)
            report_mismatch("silencer_update", "set bit", 64'd0, 64'(data[2]));
        finish_test("silencer_update", errors_at_start);
    endtask

    task automatic test_sync_update();
        int    errors_at_start;
        bit    seen;
        word_t data;
        errors_at_start = error_count;
        load_sync_words();
        host_write(ADDR_CTL_FLAG, 16'h0008);   // sync-set is bit 3
        wait_pulse(1'b1, "sync_update", seen);
        if (seen) check_sync("sync_update");
        host_read(ADDR_CTL_FLAG, data);
        if (data[3] !== 1'b0)
            report_mismatch("sync_update", "set bit", 64'd0, 64'(data[3]));
        finish_test("sync_update", errors_at_start);
    endtask

    task automatic test_priority();
        int    errors_at_start;
        int    cycles;
        bit    sil_seen;
        bit    sync_seen;
        word_t data;
        errors_at_start = error_count;
        sil_seen  = 1'b0;
        sync_seen = 1'b0;
        cycles    = 0;
        load_silencer_words();
        load_sync_words();
        host_write(ADDR_CTL_FLAG, 16'h000C);
        while (!(sil_seen && sync_seen) && cycles < 2 * PULSE_TIMEOUT) begin
            @(negedge CLK);
            cycles++;
            if (sync_update && !sil_seen)
                report_failure("priority", "sync was updated before silencer");
            if (silencer_update) sil_seen = 1'b1;
            if (sync_update) sync_seen = 1'b1;
        end
        if (!(sil_seen && sync_seen)) report_failure("priority", "an update pulse never arrived");
        check_silencer("priority");
        check_sync("priority");
        host_read(ADDR_CTL_FLAG, data);
        if (data[3:2] !== 2'b00) report_mismatch("priority", "set bits", 64'd0, 64'(data[3:2]));
        finish_test("priority", errors_at_start);
    endtask

    task automatic test_flag_outputs();
        int         errors_at_start;
        int         cycles;
        word_t      rnd;
        word_t      flags;
        logic [3:0] exp_gpio;
        errors_at_start = error_count;
        for (int round = 0; round < 4; round++) begin
            rnd         = next_random();
            exp_gpio    = rnd[4:1];
            flags       = '0;
            flags[4]    = rnd[0];   // force fan
            flags[11:8] = exp_gpio;
            host_write(ADDR_CTL_FLAG, flags);
            cycles = 0;
            @(negedge CLK);
            while ((force_fan !== rnd[0] || gpio_in !== exp_gpio) && cycles < PULSE_TIMEOUT) begin
                @(negedge CLK);
                cycles++;
            end
            if (force_fan !== rnd[0])
                report_mismatch("flag_outputs", "force_fan", 64'(rnd[0]), 64'(force_fan));
            if (gpio_in !== exp_gpio)
                report_mismatch("flag_outputs", "gpio_in", 64'(exp_gpio), 64'(gpio_in));
        end
        finish_test("flag_outputs", errors_at_start);
    endtask

    initial begin
        CLK               = 1'b0;
        rst_n             = 1'b0;
        thermo            = 1'b0;
        host_we           = 1'b0;
        host_addr         = '0;
        host_din          = '0;
        error_count       = 0;
        tests_run         = 0;
        tests_with_errors = 0;
        lcg_state         = 32'd92;
        repeat (5) @(posedge CLK);
        rst_n <= 1'b1;
        test_version_defaults();
        test_status_word();
        test_silencer_update();
        test_sync_update();
        test_priority();
        test_flag_outputs();
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_with_errors, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // the whole run needs well under a thousand cycles
    initial begin
        #100_000;
        $display("simulation stopped by the watchdog, a test hung");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

/* src.f */
common/ctl_pkg.sv
hw/cnt_ram.sv
ctl_sequencer/ctl_sequencer.sv
hw/settings_capture.sv
hw/fpga_controller.sv
sim/fpga_controller_checker.sv
sim/tb_fpga_controller.sv

/* Makefile */
TOP = tb_fpga_controller

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "failure reported in sim.log"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "no result found in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log
